// File: list.f
+incdir+logic
logic/icache_pkg.sv
logic/icache_ram.sv
logic/icache_lookup.sv
logic/icache_refill.sv
logic/icache_resp.sv
logic/icache_top.sv
tests/icache_assertions.sv
tests/icache_tb.sv

// File: logic/icache_defines.svh
`ifndef ICACHE_DEFINES_SVH
`define ICACHE_DEFINES_SVH

// fetch address split into tag, set index and byte offset
`define ICACHE_ADDR_W    32
`define ICACHE_TAG_W     20
`define ICACHE_INDEX_W   8
`define ICACHE_OFFSET_W  4

// one line holds four 32-bit words
`define ICACHE_LINE_W    128

`endif

// File: logic/icache_lookup.sv
`include "icache_defines.svh"

module icache_lookup import icache_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       req_valid,
    output logic       req_ready,
    input  fetch_req_t req,
    input  logic       inv_all,
    output logic       ram_en,
    output index_t     ram_index,
    output logic       tag0_we,
    output logic       tag1_we,
    output logic       data0_we,
    output logic       data1_we,
    output tag_t       tag_wd,
    output line_t      line_wd,
    input  tag_t       tag0_rd,
    input  tag_t       tag1_rd,
    input  line_t      line0_rd,
    input  line_t      line1_rd,
    input  logic       hold,
    output logic       hit,
    output line_t      hit_line,
    output logic [1:0] hit_offset,
    output logic       miss,
    output logic [31:0] miss_addr,
    output logic [1:0] valid_set,
    output way_t       lru_set,
    input  logic       fill_valid,
    input  fill_t      fill
);

    localparam int SETS = 1 << `ICACHE_INDEX_W;

    logic                      run_q;           // set once after reset
    logic                      stg_valid_q;
    logic [`ICACHE_ADDR_W-1:0] stg_addr_q;
    logic                      miss_pend_q;     // from miss strobe until fill
    logic                      replay_q;        // re-read of the held address
    logic [SETS-1:0]           vld0_q;
    logic [SETS-1:0]           vld1_q;
    logic [SETS-1:0]           lru_q;           // names the way to replace
    tag_t                      stg_tag;
    index_t                    stg_index;
    index_t                    req_index;
    logic                      look_ok;
    logic                      match0;
    logic                      match1;
    way_t                      hit_way;
    logic                      take;

    assign stg_tag   = stg_addr_q[`ICACHE_ADDR_W-1 -: `ICACHE_TAG_W];
    assign stg_index = stg_addr_q[`ICACHE_OFFSET_W +: `ICACHE_INDEX_W];
    assign req_index = req.addr[`ICACHE_OFFSET_W +: `ICACHE_INDEX_W];

    // array outputs are stale during the miss and the replay read
    assign look_ok = stg_valid_q & ~miss_pend_q & ~replay_q;
    assign match0  = vld0_q[stg_index] & (tag0_rd == stg_tag);
    assign match1  = vld1_q[stg_index] & (tag1_rd == stg_tag);
    assign hit_way = match1;

    assign hit        = look_ok & (match0 | match1);
    assign miss       = look_ok & ~(match0 | match1);
    assign hit_line   = hit_way ? line1_rd : line0_rd;
    assign hit_offset = stg_addr_q[`ICACHE_OFFSET_W-1:2];
    assign miss_addr  = stg_addr_q;
    assign valid_set  = {vld1_q[stg_index], vld0_q[stg_index]};
    assign lru_set    = lru_q[stg_index];

    assign req_ready = run_q & ~hold & ~miss_pend_q & ~replay_q & ~miss;
    assign take      = req_valid & req_ready;

    always_comb begin
        if (fill_valid) begin
            ram_index = fill.index;
        end else if (replay_q) begin
            ram_index = stg_index;
        end else begin
            ram_index = req_index;
        end
    end

    assign ram_en   = fill_valid | replay_q | take;
    assign tag0_we  = fill_valid & (fill.way == 1'b0);
    assign tag1_we  = fill_valid & (fill.way == 1'b1);
    assign data0_we = fill_valid & (fill.way == 1'b0);
    assign data1_we = fill_valid & (fill.way == 1'b1);
    assign tag_wd   = fill.tag;
    assign line_wd  = fill.line;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            run_q       <= 1'b0;
            stg_valid_q <= 1'b0;
            miss_pend_q <= 1'b0;
            replay_q    <= 1'b0;
        end else begin
            run_q    <= 1'b1;
            replay_q <= fill_valid;
            if (miss) begin
                miss_pend_q <= 1'b1;
            end else if (fill_valid) begin
                miss_pend_q <= 1'b0;
            end
            if (take) begin
                stg_valid_q <= 1'b1;
            end else if (hit && !hold) begin
                stg_valid_q <= 1'b0;        // drained into the response register
            end
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            stg_addr_q <= req.addr;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            vld0_q <= '0;
            vld1_q <= '0;
            lru_q  <= '0;
        end else begin
            if (inv_all && !miss_pend_q) begin
                vld0_q <= '0;
                vld1_q <= '0;
            end else if (fill_valid) begin
                if (fill.way) begin
                    vld1_q[fill.index] <= 1'b1;
                end else begin
                    vld0_q[fill.index] <= 1'b1;
                end
            end
            // the other way becomes least recently used
            if (fill_valid) begin
                lru_q[fill.index] <= ~fill.way;
            end else if (hit && !hold) begin
                lru_q[stg_index] <= ~hit_way;
            end
        end
    end

endmodule

// File: logic/icache_pkg.sv
`include "icache_defines.svh"

package icache_pkg;

    typedef logic [`ICACHE_TAG_W-1:0]   tag_t;
    typedef logic [`ICACHE_INDEX_W-1:0] index_t;
    typedef logic [`ICACHE_LINE_W-1:0]  line_t;     // word 0 in the low bits

    typedef logic way_t;                            // 0 or 1

    typedef struct packed {
        logic [`ICACHE_ADDR_W-1:0] addr;            // byte address of the fetch
    } fetch_req_t;

    typedef struct packed {
        logic [31:0] data;                          // instruction word
    } fetch_resp_t;

    // one refill write into the arrays
    typedef struct packed {
        way_t   way;
        index_t index;
        tag_t   tag;
        line_t  line;
    } fill_t;

endpackage

// File: logic/icache_ram.sv
module icache_ram import icache_pkg::*; #(
    parameter type entry_t = logic,
    parameter int  depth   = 256
) (
    input  logic   clk,
    input  logic   en,
    input  logic   we,
    input  index_t addr,
    input  entry_t wd,
    output entry_t rd
);

    entry_t mem [depth];

    // read-first, rd keeps its value while en is low
    always_ff @(posedge clk) begin
        if (en) begin
            if (we) begin
                mem[addr] <= wd;
            end
            rd <= mem[addr];            // old entry on a write cycle
        end
    end

endmodule

// File: logic/icache_refill.sv
`include "icache_defines.svh"

module icache_refill import icache_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        miss,
    input  logic [31:0] miss_addr,
    input  logic [1:0]  valid_set,
    input  way_t        lru_set,
    output logic        l2_req_valid,
    input  logic        l2_req_ready,
    output logic [31:0] l2_addr,
    input  logic        l2_resp_valid,
    input  line_t       l2_line,
    output logic        fill_valid,
    output fill_t       fill
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_REQ,
        ST_WAIT,
        ST_FILL
    } state_t;

    state_t      state_q;
    state_t      state_d;
    logic [31:0] addr_q;            // missing fetch address
    way_t        way_q;             // victim chosen at the miss
    line_t       line_q;            // line returned by L2
    way_t        victim;

    // invalid ways first, then the LRU choice
    always_comb begin
        if (!valid_set[0]) begin
            victim = 1'b0;
        end else if (!valid_set[1]) begin
            victim = 1'b1;
        end else begin
            victim = lru_set;
        end
    end

    always_comb begin
        state_d = state_q;
        case (state_q)
            ST_IDLE: begin
                if (miss) begin
                    state_d = ST_REQ;
                end
            end
            ST_REQ: begin
                if (l2_req_ready) begin
                    state_d = ST_WAIT;
                end
            end
            ST_WAIT: begin
                if (l2_resp_valid) begin
                    state_d = ST_FILL;
                end
            end
            ST_FILL: begin
                state_d = ST_IDLE;      // single write cycle
            end
            default: begin
                state_d = ST_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= ST_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    always_ff @(posedge clk) begin
        if (state_q == ST_IDLE && miss) begin
            addr_q <= miss_addr;
            way_q  <= victim;
        end
        if (state_q == ST_WAIT && l2_resp_valid) begin
            line_q <= l2_line;
        end
    end

    assign l2_req_valid = (state_q == ST_REQ);
    assign l2_addr      = {addr_q[`ICACHE_ADDR_W-1:`ICACHE_OFFSET_W], {`ICACHE_OFFSET_W{1'b0}}};

    assign fill_valid = (state_q == ST_FILL);
    assign fill.way   = way_q;
    assign fill.index = addr_q[`ICACHE_OFFSET_W +: `ICACHE_INDEX_W];
    assign fill.tag   = addr_q[`ICACHE_ADDR_W-1 -: `ICACHE_TAG_W];
    assign fill.line  = line_q;

endmodule

// File: logic/icache_resp.sv
module icache_resp import icache_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        hit,
    input  line_t       hit_line,
    input  logic [1:0]  hit_offset,
    output logic        hold,
    output logic        resp_valid,
    input  logic        resp_ready,
    output fetch_resp_t resp
);

    logic [31:0] word;
    logic        load;

    // word 0 sits in the low 32 bits of the line
    always_comb begin
        case (hit_offset)
            2'd0:    word = hit_line[31:0];
            2'd1:    word = hit_line[63:32];
            2'd2:    word = hit_line[95:64];
            default: word = hit_line[127:96];
        endcase
    end

    assign hold = resp_valid & ~resp_ready;     // full and not draining
    assign load = hit & ~hold;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            resp_valid <= 1'b0;
        end else if (!hold) begin
            resp_valid <= hit;
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            resp.data <= word;
        end
    end

endmodule

// File: logic/icache_top.sv
`include "icache_defines.svh"

module icache_top import icache_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        req_valid,
    output logic        req_ready,
    input  fetch_req_t  req,
    output logic        resp_valid,
    input  logic        resp_ready,
    output fetch_resp_t resp,
    input  logic        inv_all,
    output logic        l2_req_valid,
    input  logic        l2_req_ready,
    output logic [31:0] l2_addr,
    input  logic        l2_resp_valid,
    input  line_t       l2_line
);

    localparam int SETS = 1 << `ICACHE_INDEX_W;

    logic        ram_en;
    index_t      ram_index;
    logic        tag0_we;
    logic        tag1_we;
    logic        data0_we;
    logic        data1_we;
    tag_t        tag_wd;
    line_t       line_wd;
    tag_t        tag0_rd;
    tag_t        tag1_rd;
    line_t       line0_rd;
    line_t       line1_rd;
    logic        hold;
    logic        hit;
    line_t       hit_line;
    logic [1:0]  hit_offset;
    logic        miss;
    logic [31:0] miss_addr;
    logic [1:0]  valid_set;
    way_t        lru_set;
    logic        fill_valid;
    fill_t       fill;

    // tag and data arrays per way
    icache_ram #(.entry_t(tag_t), .depth(SETS)) tag0_ram (
        .clk(clk), .en(ram_en), .we(tag0_we), .addr(ram_index), .wd(tag_wd), .rd(tag0_rd)
    );
    icache_ram #(.entry_t(tag_t), .depth(SETS)) tag1_ram (
        .clk(clk), .en(ram_en), .we(tag1_we), .addr(ram_index), .wd(tag_wd), .rd(tag1_rd)
    );
    icache_ram #(.entry_t(line_t), .depth(SETS)) data0_ram (
        .clk(clk), .en(ram_en), .we(data0_we), .addr(ram_index), .wd(line_wd), .rd(line0_rd)
    );
    icache_ram #(.entry_t(line_t), .depth(SETS)) data1_ram (
        .clk(clk), .en(ram_en), .we(data1_we), .addr(ram_index), .wd(line_wd), .rd(line1_rd)
    );

    icache_lookup lookup0 (
        .clk(clk), .rst_n(rst_n),
        .req_valid(req_valid), .req_ready(req_ready), .req(req),
        .inv_all(inv_all),
        .ram_en(ram_en), .ram_index(ram_index),
        .tag0_we(tag0_we), .tag1_we(tag1_we), .data0_we(data0_we), .data1_we(data1_we),
        .tag_wd(tag_wd), .line_wd(line_wd),
        .tag0_rd(tag0_rd), .tag1_rd(tag1_rd), .line0_rd(line0_rd), .line1_rd(line1_rd),
        .hold(hold),
        .hit(hit), .hit_line(hit_line), .hit_offset(hit_offset),
        .miss(miss), .miss_addr(miss_addr),
        .valid_set(valid_set), .lru_set(lru_set),
        .fill_valid(fill_valid), .fill(fill)
    );

    icache_refill refill0 (
        .clk(clk), .rst_n(rst_n),
        .miss(miss), .miss_addr(miss_addr),
        .valid_set(valid_set), .lru_set(lru_set),
        .l2_req_valid(l2_req_valid), .l2_req_ready(l2_req_ready), .l2_addr(l2_addr),
        .l2_resp_valid(l2_resp_valid), .l2_line(l2_line),
        .fill_valid(fill_valid), .fill(fill)
    );

    icache_resp resp0 (
        .clk(clk), .rst_n(rst_n),
        .hit(hit), .hit_line(hit_line), .hit_offset(hit_offset),
        .hold(hold),
        .resp_valid(resp_valid), .resp_ready(resp_ready), .resp(resp)
    );

endmodule

// File: tests/icache_assertions.sv
module icache_assertions import icache_pkg::*; (
    input logic        clk,
    input logic        rst_n,
    input logic        req_valid,
    input logic        req_ready,
    input fetch_req_t  req,
    input logic        resp_valid,
    input logic        resp_ready,
    input fetch_resp_t resp,
    input logic        l2_req_valid,
    input logic        l2_req_ready,
    input logic [31:0] l2_addr,
    input logic        hit,
    input logic        miss,
    input logic        hold
);
    timeunit 1ns;
    timeprecision 100ps;

    int          fail_count = 0;
    logic [31:0] addr_fifo [4];         // accepted fetches not yet answered
    logic [1:0]  wr_ptr;
    logic [1:0]  rd_ptr;
    logic        take;
    logic        give;
    logic [31:0] exp_word;

    assign take     = req_valid & req_ready;
    assign give     = resp_valid & resp_ready;
    assign exp_word = {addr_fifo[rd_ptr][31:2], 2'b00} ^ 32'h5a5a_0000;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (take) begin
                wr_ptr <= wr_ptr + 2'd1;
            end
            if (give) begin
                rd_ptr <= rd_ptr + 2'd1;    // oldest one answered
            end
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            addr_fifo[wr_ptr] <= req.addr;
        end
    end

    a_reset_low: assert property (@(posedge clk)
        !rst_n |-> !req_ready && !resp_valid && !l2_req_valid)
        else begin
            fail_count++;
            $error("handshake outputs not low during reset");
        end

    a_resp_owner: assert property (@(posedge clk) disable iff (!rst_n)
        resp_valid |-> wr_ptr != rd_ptr)
        else begin
            fail_count++;
            $error("response without an outstanding fetch");
        end

    a_resp_data: assert property (@(posedge clk) disable iff (!rst_n)
        resp_valid |-> resp.data == exp_word)
        else begin
            fail_count++;
            $error("response word %h, expected %h", resp.data, exp_word);
        end

    a_resp_stable: assert property (@(posedge clk) disable iff (!rst_n)
        resp_valid && !resp_ready |=> resp_valid && $stable(resp))
        else begin
            fail_count++;
            $error("stalled response changed or dropped");
        end

    a_lookup_strobe: assert property (@(posedge clk) disable iff (!rst_n)
        take |=> hit || miss)
        else begin
            fail_count++;
            $error("no hit or miss one cycle after acceptance");
        end

    a_hit_latency: assert property (@(posedge clk) disable iff (!rst_n)
        take ##1 (!miss && !hold) |=> resp_valid)
        else begin
            fail_count++;
            $error("hit response not valid two cycles after acceptance");
        end

    a_hit_pipeline: assert property (@(posedge clk) disable iff (!rst_n)
        take ##1 (hit && resp_ready) |-> req_ready)
        else begin
            fail_count++;
            $error("intake stalled behind a hit");
        end

    a_l2_hold: assert property (@(posedge clk) disable iff (!rst_n)
        l2_req_valid && !l2_req_ready |=> l2_req_valid && $stable(l2_addr))
        else begin
            fail_count++;
            $error("L2 request dropped or changed before ready");
        end

    a_l2_align: assert property (@(posedge clk) disable iff (!rst_n)
        l2_req_valid |-> l2_addr[3:0] == 4'h0)
        else begin
            fail_count++;
            $error("L2 address %h not line aligned", l2_addr);
        end

endmodule

bind icache_top icache_assertions asrt0 (.*);

// File: tests/icache_tb.sv
`include "icache_defines.svh"

module icache_tb import icache_pkg::*;;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int SETS = 1 << `ICACHE_INDEX_W;

    logic        clk;
    logic        rst_n;
    logic        req_valid;
    logic        req_ready;
    fetch_req_t  req;
    logic        resp_valid;
    logic        resp_ready;
    fetch_resp_t resp;
    logic        inv_all;
    logic        l2_req_valid;
    logic        l2_req_ready;
    logic [31:0] l2_addr;
    logic        l2_resp_valid;
    line_t       l2_line;

    logic [31:0] rng = 32'he0a4_bdc8;
    logic        rand_ready;        // random resp_ready stalls
    logic        timed_out;
    int          acc_count;
    int          resp_count;
    int          l2_seen;           // observed L2 request transfers
    int          l2_wait;
    logic [31:0] l2_pend_addr;
    int          exp_l2;            // L2 requests predicted by the model
    int          exp_base;
    int          obs_base;
    int          asrt_base;
    int          tests_pass;
    int          tests_fail;
    logic        m_vld0 [SETS];
    logic        m_vld1 [SETS];
    tag_t        m_tag0 [SETS];
    tag_t        m_tag1 [SETS];
    logic        m_lru  [SETS];     // way to replace next

    icache_top dut0 (
        .clk(clk), .rst_n(rst_n),
        .req_valid(req_valid), .req_ready(req_ready), .req(req),
        .resp_valid(resp_valid), .resp_ready(resp_ready), .resp(resp),
        .inv_all(inv_all),
        .l2_req_valid(l2_req_valid), .l2_req_ready(l2_req_ready), .l2_addr(l2_addr),
        .l2_resp_valid(l2_resp_valid), .l2_line(l2_line)
    );

    always #50 clk = ~clk;

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // word i holds its own byte address xor the L2 pattern
    function automatic line_t make_line(input logic [31:0] addr);
        line_t l;
        for (int i = 0; i < 4; i++) begin
            l[32*i +: 32] = ({addr[31:4], 4'h0} + 32'(4 * i)) ^ 32'h5a5a_0000;
        end
        return l;
    endfunction

    // L2 model, random ready and 2 to 5 cycles to the line
    initial begin
        l2_req_ready  = 1'b0;
        l2_resp_valid = 1'b0;
        l2_line       = '0;
        l2_wait       = 0;
        forever begin
            @(negedge clk);
            if (l2_req_valid && l2_req_ready) begin
                l2_pend_addr = l2_addr;
                rng          = xorshift(rng);
                l2_wait      = 2 + int'(rng[3:2]);
                l2_seen++;
            end
            @(posedge clk);
            #5;
            l2_req_ready  = 1'b0;
            l2_resp_valid = 1'b0;
            if (l2_wait > 0) begin
                l2_wait--;
                if (l2_wait == 0) begin
                    l2_resp_valid = 1'b1;
                    l2_line       = make_line(l2_pend_addr);
                end
            end else if (l2_req_valid) begin
                rng          = xorshift(rng);
                l2_req_ready = rng[0] | rng[1];
            end
        end
    end

    // response sink
    initial begin
        resp_ready = 1'b1;
        forever begin
            @(negedge clk);
            if (resp_valid && resp_ready) begin
                resp_count++;
            end
            @(posedge clk);
            #5;
            if (rand_ready) begin
                rng        = xorshift(rng);
                resp_ready = rng[0];
            end else begin
                resp_ready = 1'b1;
            end
        end
    end

    task automatic model_access(input logic [31:0] addr);
        int   s;
        tag_t t;
        logic w;
        s = int'(addr[`ICACHE_OFFSET_W +: `ICACHE_INDEX_W]);
        t = addr[`ICACHE_ADDR_W-1 -: `ICACHE_TAG_W];
        if (m_vld0[s] && m_tag0[s] == t) begin
            m_lru[s] = 1'b1;
        end else if (m_vld1[s] && m_tag1[s] == t) begin
            m_lru[s] = 1'b0;
        end else begin
            exp_l2++;
            if (!m_vld0[s]) begin
                w = 1'b0;
            end else if (!m_vld1[s]) begin
                w = 1'b1;
            end else begin
                w = m_lru[s];
            end
            if (w) begin
                m_vld1[s] = 1'b1;
                m_tag1[s] = t;
            end else begin
                m_vld0[s] = 1'b1;
                m_tag0[s] = t;
            end
            m_lru[s] = ~w;
        end
    endtask

    // called and returns a few ns after a rising edge
    task automatic fetch(input logic [31:0] addr);
        int n;
        if (timed_out) begin
            return;
        end
        model_access(addr);
        req_valid = 1'b1;
        req.addr  = addr;
        n = 0;
        @(negedge clk);
        while (!req_ready && n < 500) begin
            n++;
            @(negedge clk);
        end
        if (!req_ready) begin
            $display("timeout: fetch of %h was never accepted", addr);
            timed_out = 1'b1;
        end else begin
            acc_count++;
        end
        @(posedge clk);
        #5;
        req_valid = 1'b0;
    endtask

    task automatic drain();
        int n;
        n = 0;
        while (!timed_out && (resp_count != acc_count || l2_req_valid || l2_wait != 0)) begin
            @(negedge clk);
            n++;
            if (n > 500) begin
                $display("timeout: %0d responses still missing after 500 cycles",
                         acc_count - resp_count);
                timed_out = 1'b1;
            end
        end
        @(posedge clk);
        #5;
    endtask

    task automatic invalidate();
        inv_all = 1'b1;
        @(posedge clk);
        #5;
        inv_all = 1'b0;
        for (int s = 0; s < SETS; s++) begin
            m_vld0[s] = 1'b0;
            m_vld1[s] = 1'b0;
        end
    endtask

    task automatic start_test();
        exp_base  = exp_l2;
        obs_base  = l2_seen;
        asrt_base = dut0.asrt0.fail_count;
    endtask

    task automatic end_test(input string name);
        int exp_n;
        int obs_n;
        int asrt_n;
        drain();
        exp_n  = exp_l2 - exp_base;
        obs_n  = l2_seen - obs_base;
        asrt_n = dut0.asrt0.fail_count - asrt_base;
        if (timed_out) begin
            $display("%s did not finish because a wait timed out", name);
            tests_fail++;
        end else if (exp_n != obs_n) begin
            $display("[FAIL] %s: l2 requests expected %0d actual %0d", name, exp_n, obs_n);
            tests_fail++;
        end else if (asrt_n != 0) begin
            $display("%s broke %0d assertion checks", name, asrt_n);
            tests_fail++;
        end else begin
            $display("[PASS] %s", name);
            tests_pass++;
        end
    endtask

    initial begin
        clk        = 1'b0;
        rst_n      = 1'b1;
        req_valid  = 1'b0;
        req        = '0;
        inv_all    = 1'b0;
        rand_ready = 1'b0;
        timed_out  = 1'b0;
        for (int s = 0; s < SETS; s++) begin
            m_vld0[s] = 1'b0;
            m_vld1[s] = 1'b0;
            m_tag0[s] = '0;
            m_tag1[s] = '0;
            m_lru[s]  = 1'b0;
        end
        #10 rst_n = 1'b0;
        repeat (8) @(posedge clk);
        #5;
        rst_n = 1'b1;

        start_test();
        fetch(32'h0000_2004);                   // first fetch misses
        end_test("reset_state");

        start_test();
        for (int i = 0; i < 4; i++) begin
            fetch(32'h0000_0100 + 32'(4 * i));
        end
        end_test("cold_miss");

        // both lines are already cached
        start_test();
        for (int i = 0; i < 8; i++) begin
            if (i % 2 == 0) begin
                fetch(32'h0000_0100 + 32'(4 * (i / 2)));
            end else begin
                fetch(32'h0000_2000 + 32'(4 * (i / 2)));
            end
        end
        end_test("pipelined_hits");

        // A, B and C all map to set 0x40
        start_test();
        fetch(32'h0001_0400);
        fetch(32'h0002_0400);
        fetch(32'h0001_0400);
        fetch(32'h0003_0400);
        end_test("replace_fill");
        start_test();
        fetch(32'h0001_0404);
        end_test("replace_keep_a");
        start_test();
        fetch(32'h0002_0408);
        end_test("replace_refetch_b");

        start_test();
        rand_ready = 1'b1;
        for (int i = 0; i < 40; i++) begin
            rng = xorshift(rng);
            fetch({18'h0, rng[1:0], 6'h04, rng[3:2], rng[5:4], 2'b00});
        end
        rand_ready = 1'b0;
        end_test("backpressure");

        start_test();
        fetch(32'h0000_0108);                   // line cached before the flush
        drain();
        invalidate();
        fetch(32'h0000_0108);
        end_test("invalidate");

        $display("tests passed %0d, failed %0d, assertion errors %0d",
                 tests_pass, tests_fail, dut0.asrt0.fail_count);
        if (tests_fail == 0 && !timed_out && dut0.asrt0.fail_count == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule
